// ==== common/maint_pkg.sv ====
/*
 * widths, memory window and init sizes for the maintenance block
 * word and address types, init phase enum
 */

`default_nettype none

package maint_pkg;

    localparam int WORD_W      = 32;
    localparam int ADDR_W      = 32;
    localparam int ADDR_MASK_W = 26;   // low bits kept for the memory window

    localparam int ZERO_WORDS   = 16;  // cleared from address 0
    localparam int IMAGE_WORDS  = 8;   // must not exceed ZERO_WORDS
    localparam int LOAD_CREDITS = 2;   // also the stream buffer depth

    // stream buffer pointer and fill counter widths
    localparam int LD_PTR_W = (LOAD_CREDITS > 1) ? $clog2(LOAD_CREDITS) : 1;
    localparam int LD_CNT_W = $clog2(LOAD_CREDITS + 1);

    typedef logic [WORD_W-1:0] word_t;  // data and checksums
    typedef logic [ADDR_W-1:0] addr_t;  // byte address, steps by 4

    typedef enum logic [1:0] {
        PH_ZERO,
        PH_LOAD,
        PH_VERIFY,
        PH_DONE
    } init_phase_e;

endpackage

`default_nettype wire

// ==== common/mem_req_if.sv ====
/*
 * one memory request path
 * req/busy handshake, requester and server modports
 */

`timescale 1ns/1ps
`default_nettype none

interface mem_req_if;

    logic             req;
    logic             we;
    maint_pkg::addr_t addr;
    maint_pkg::word_t wdata;
    maint_pkg::word_t rdata;  // valid in the cycle busy falls
    logic             busy;

    modport requester (
        output req, we, addr, wdata,
        input  rdata, busy
    );

    modport server (
        input  req, we, addr, wdata,
        output rdata, busy
    );

endinterface

`default_nettype wire

// ==== hw/init/init_sequencer.sv ====
/*
 * init phase sequencer: zero fill, image load, readback verify
 * address counter, stream word buffer with credit return
 */

`timescale 1ns/1ps
`default_nettype none

module init_sequencer (
    input  wire logic                   clk,
    input  wire logic                   i_rst_n,
    input  wire logic                   i_ld_valid,
    input  wire maint_pkg::word_t       i_ld_data,
    output logic                        o_ld_credit,
    mem_req_if.requester                mem,
    output maint_pkg::init_phase_e      o_phase,
    output logic                        o_load_strobe,
    output maint_pkg::word_t            o_load_data,
    output logic                        o_verify_strobe,
    output maint_pkg::word_t            o_verify_data
);

    // handshake progress of the single operation in flight
    typedef enum logic [1:0] {
        OP_IDLE,
        OP_ISSUE,
        OP_WAIT_HI,
        OP_WAIT_LO
    } op_state_e;

    maint_pkg::init_phase_e r_phase;
    op_state_e              r_op;
    maint_pkg::addr_t       r_addr;
    maint_pkg::addr_t       last_addr;
    logic                   r_req;
    logic                   r_credit;
    logic                   have_work;
    logic                   op_done;

    maint_pkg::word_t                  fifo_mem [maint_pkg::LOAD_CREDITS];
    logic [maint_pkg::LD_PTR_W-1:0]    r_wr_ptr;
    logic [maint_pkg::LD_PTR_W-1:0]    r_rd_ptr;
    logic [maint_pkg::LD_CNT_W-1:0]    r_count;
    logic                              fifo_empty;
    logic                              fifo_full;
    logic                              push;
    logic                              pop;

    assign fifo_empty = (r_count == '0);
    assign fifo_full  = (r_count == maint_pkg::LD_CNT_W'(maint_pkg::LOAD_CREDITS));
    assign op_done    = (r_op == OP_WAIT_LO) && !mem.busy;
    assign push       = i_ld_valid;  // words may arrive in any phase
    assign pop        = op_done && (r_phase == maint_pkg::PH_LOAD);

    always_comb begin
        have_work = 1'b0;
        last_addr = maint_pkg::addr_t'((maint_pkg::IMAGE_WORDS - 1) * 4);
        case (r_phase)
            maint_pkg::PH_ZERO: begin
                have_work = 1'b1;
                last_addr = maint_pkg::addr_t'((maint_pkg::ZERO_WORDS - 1) * 4);
            end
            maint_pkg::PH_LOAD:   have_work = !fifo_empty;
            maint_pkg::PH_VERIFY: have_work = 1'b1;
            default:              have_work = 1'b0;
        endcase
    end

    // phase and address advance on completion
    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            r_phase <= maint_pkg::PH_ZERO;
            r_addr  <= '0;
        end else if (op_done) begin
            if (r_addr == last_addr) begin
                r_addr <= '0;
                case (r_phase)
                    maint_pkg::PH_ZERO: r_phase <= maint_pkg::PH_LOAD;
                    maint_pkg::PH_LOAD: r_phase <= maint_pkg::PH_VERIFY;
                    default:            r_phase <= maint_pkg::PH_DONE;
                endcase
            end else begin
                r_addr <= r_addr + maint_pkg::addr_t'(4);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            r_op  <= OP_IDLE;
            r_req <= 1'b0;
        end else begin
            case (r_op)
                OP_IDLE: if (have_work && !mem.busy) begin
                    r_req <= 1'b1;
                    r_op  <= OP_ISSUE;
                end
                OP_ISSUE: if (!mem.busy) begin  // taken this cycle
                    r_req <= 1'b0;
                    r_op  <= OP_WAIT_HI;
                end
                OP_WAIT_HI: if (mem.busy) r_op <= OP_WAIT_LO;
                default:    if (!mem.busy) r_op <= OP_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            r_wr_ptr <= '0;
            r_rd_ptr <= '0;
            r_count  <= '0;
            r_credit <= 1'b0;
        end else begin
            r_credit <= pop;  // one credit back per word written
            if (push) begin
                r_wr_ptr <= (r_wr_ptr == maint_pkg::LD_PTR_W'(maint_pkg::LOAD_CREDITS - 1)) ?
                            '0 : r_wr_ptr + 1'b1;
            end
            if (pop) begin
                r_rd_ptr <= (r_rd_ptr == maint_pkg::LD_PTR_W'(maint_pkg::LOAD_CREDITS - 1)) ?
                            '0 : r_rd_ptr + 1'b1;
            end
            if (push && !pop)
                r_count <= r_count + 1'b1;
            else if (pop && !push)
                r_count <= r_count - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (push) fifo_mem[r_wr_ptr] <= i_ld_data;
    end

    assign mem.req   = r_req;
    assign mem.we    = (r_phase != maint_pkg::PH_VERIFY);
    assign mem.addr  = r_addr;
    assign mem.wdata = (r_phase == maint_pkg::PH_LOAD) ? fifo_mem[r_rd_ptr] : '0;

    assign o_phase         = r_phase;
    assign o_ld_credit     = r_credit;
    assign o_load_strobe   = push;
    assign o_load_data     = i_ld_data;
    assign o_verify_strobe = op_done && (r_phase == maint_pkg::PH_VERIFY);
    assign o_verify_data   = mem.rdata;  // read data valid as busy falls

    // source only sends while holding a credit
    a_no_overrun: assert property (@(posedge clk) disable iff (!i_rst_n)
        !(i_ld_valid && fifo_full));

    a_req_rise_idle: assert property (@(posedge clk) disable iff (!i_rst_n)
        $rose(mem.req) |-> !mem.busy);

endmodule

`default_nettype wire

// ==== hw/init/checksum_unit.sv ====
/*
 * load and verify checksum accumulators, end-of-init match flag
 */

`timescale 1ns/1ps
`default_nettype none

module checksum_unit (
    input  wire logic                   clk,
    input  wire logic                   i_rst_n,
    input  wire maint_pkg::init_phase_e i_phase,
    input  wire logic                   i_load_strobe,
    input  wire maint_pkg::word_t       i_load_data,
    input  wire logic                   i_verify_strobe,
    input  wire maint_pkg::word_t       i_verify_data,
    output maint_pkg::word_t            o_load_checksum,
    output logic                        o_verify_ok
);

    maint_pkg::word_t r_load_sum;
    maint_pkg::word_t r_verify_sum;
    maint_pkg::word_t verify_sum_nxt;
    logic             r_match;

    assign verify_sum_nxt = r_verify_sum + (i_verify_strobe ? i_verify_data : '0);

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            r_load_sum   <= '0;
            r_verify_sum <= '0;
            r_match      <= 1'b0;
        end else begin
            if (i_load_strobe) r_load_sum <= r_load_sum + i_load_data;  // wraps mod 2^32
            if (i_verify_strobe) r_verify_sum <= verify_sum_nxt;
            // tracks through verify, frozen once the phase moves on
            if (i_phase == maint_pkg::PH_VERIFY)
                r_match <= (verify_sum_nxt == r_load_sum);
        end
    end

    assign o_load_checksum = r_load_sum;
    assign o_verify_ok     = r_match && (i_phase == maint_pkg::PH_DONE);

    a_no_strobe_done: assert property (@(posedge clk) disable iff (!i_rst_n)
        (i_load_strobe || i_verify_strobe) |-> (i_phase != maint_pkg::PH_DONE));

endmodule

`default_nettype wire

// ==== hw/mem_port_mux.sv ====
/*
 * memory port select between init path and user bus
 * user address masking, user busy until init is done
 */

`timescale 1ns/1ps
`default_nettype none

module mem_port_mux (
    input  wire maint_pkg::init_phase_e i_phase,
    mem_req_if.server                   init,
    input  wire logic                   i_usr_rd,
    input  wire logic                   i_usr_wr,
    input  wire maint_pkg::addr_t       i_usr_addr,
    input  wire maint_pkg::word_t       i_usr_wdata,
    output maint_pkg::word_t            o_usr_rdata,
    output logic                        o_usr_busy,
    output logic                        o_mem_req,
    output logic                        o_mem_we,
    output maint_pkg::addr_t            o_mem_addr,
    output maint_pkg::word_t            o_mem_wdata,
    input  wire maint_pkg::word_t       i_mem_rdata,
    input  wire logic                   i_mem_busy
);

    logic             usr_active;
    maint_pkg::addr_t usr_addr_masked;

    assign usr_active = (i_phase == maint_pkg::PH_DONE);

    // only the memory window bits reach the controller
    assign usr_addr_masked = {
        {(maint_pkg::ADDR_W - maint_pkg::ADDR_MASK_W){1'b0}},
        i_usr_addr[maint_pkg::ADDR_MASK_W-1:0]
    };

    assign o_mem_req   = usr_active ? (i_usr_rd | i_usr_wr) : init.req;
    assign o_mem_we    = usr_active ? i_usr_wr : init.we;
    assign o_mem_addr  = usr_active ? usr_addr_masked : init.addr;
    assign o_mem_wdata = usr_active ? i_usr_wdata : init.wdata;

    assign init.rdata  = i_mem_rdata;
    assign init.busy   = i_mem_busy | usr_active;  // init path closed after hand-off

    assign o_usr_rdata = i_mem_rdata;
    assign o_usr_busy  = usr_active ? i_mem_busy : 1'b1;  // requests dropped until done

    always_comb begin
        a_usr_rd_wr_excl: assert final (!(i_usr_rd && i_usr_wr));
    end

endmodule

`default_nettype wire

// ==== hw/maint_top.sv ====
/*
 * boot-time memory maintenance top level
 * sequencer, checksum unit and memory port mux
 */

`timescale 1ns/1ps
`default_nettype none

module maint_top (
    input  wire logic             clk,
    input  wire logic             i_rst_n,
    // boot image stream
    input  wire logic             i_ld_valid,
    input  wire maint_pkg::word_t i_ld_data,
    output logic                  o_ld_credit,
    // user bus
    input  wire logic             i_usr_rd,
    input  wire logic             i_usr_wr,
    input  wire maint_pkg::addr_t i_usr_addr,
    input  wire maint_pkg::word_t i_usr_wdata,
    output maint_pkg::word_t      o_usr_rdata,
    output logic                  o_usr_busy,
    // external memory controller
    output logic                  o_mem_req,
    output logic                  o_mem_we,
    output maint_pkg::addr_t      o_mem_addr,
    output maint_pkg::word_t      o_mem_wdata,
    input  wire maint_pkg::word_t i_mem_rdata,
    input  wire logic             i_mem_busy,
    // status
    output logic                  o_init_done,
    output logic                  o_verify_ok,
    output maint_pkg::word_t      o_load_checksum
);

    maint_pkg::init_phase_e phase;
    logic                   load_strobe;
    maint_pkg::word_t       load_data;
    logic                   verify_strobe;
    maint_pkg::word_t       verify_data;

    mem_req_if init_if ();

    init_sequencer u_init_sequencer (
        .clk            (clk),
        .i_rst_n        (i_rst_n),
        .i_ld_valid     (i_ld_valid),
        .i_ld_data      (i_ld_data),
        .o_ld_credit    (o_ld_credit),
        .mem            (init_if.requester),
        .o_phase        (phase),
        .o_load_strobe  (load_strobe),
        .o_load_data    (load_data),
        .o_verify_strobe(verify_strobe),
        .o_verify_data  (verify_data)
    );

    checksum_unit u_checksum_unit (
        .clk            (clk),
        .i_rst_n        (i_rst_n),
        .i_phase        (phase),
        .i_load_strobe  (load_strobe),
        .i_load_data    (load_data),
        .i_verify_strobe(verify_strobe),
        .i_verify_data  (verify_data),
        .o_load_checksum(o_load_checksum),
        .o_verify_ok    (o_verify_ok)
    );

    mem_port_mux u_mem_port_mux (
        .i_phase    (phase),
        .init       (init_if.server),
        .i_usr_rd   (i_usr_rd),
        .i_usr_wr   (i_usr_wr),
        .i_usr_addr (i_usr_addr),
        .i_usr_wdata(i_usr_wdata),
        .o_usr_rdata(o_usr_rdata),
        .o_usr_busy (o_usr_busy),
        .o_mem_req  (o_mem_req),
        .o_mem_we   (o_mem_we),
        .o_mem_addr (o_mem_addr),
        .o_mem_wdata(o_mem_wdata),
        .i_mem_rdata(i_mem_rdata),
        .i_mem_busy (i_mem_busy)
    );

    assign o_init_done = (phase == maint_pkg::PH_DONE);

endmodule

`default_nettype wire

// ==== sim/mem_model.sv ====
/*
 * behavioral memory for the testbench
 * req/busy handshake, busy length per request, address-based fill
 */

`timescale 1ns/1ps
`default_nettype none

module mem_model (
    input  wire logic             clk,
    input  wire logic             i_rst_n,
    input  wire logic             i_req,
    input  wire logic             i_we,
    input  wire maint_pkg::addr_t i_addr,
    input  wire maint_pkg::word_t i_wdata,
    input  wire logic [2:0]       i_busy_len,  // cycles of busy, 0 counts as 1
    output maint_pkg::word_t      o_rdata,
    output logic                  o_busy
);

    maint_pkg::word_t store [maint_pkg::addr_t];  // keyed by word address
    logic             r_we;
    maint_pkg::addr_t r_addr;
    maint_pkg::word_t r_wdata;
    int               r_left;

    // unwritten words read back a pattern of the full word address, never zero
    function automatic maint_pkg::word_t fill_word(input maint_pkg::addr_t key);
        return (key ^ 32'hDEAD_BEEF) | 32'h1;
    endfunction

    always @(posedge clk) begin
        if (!i_rst_n) begin
            o_busy  <= 1'b0;
            o_rdata <= '0;
            r_left  <= 0;
        end else if (!o_busy) begin
            if (i_req) begin  // accepted, busy from next cycle
                r_we    <= i_we;
                r_addr  <= i_addr;
                r_wdata <= i_wdata;
                r_left  <= (i_busy_len == 3'd0) ? 1 : int'(i_busy_len);
                o_busy  <= 1'b1;
            end
        end else if (r_left > 1) begin
            r_left <= r_left - 1;
        end else begin
            o_busy <= 1'b0;  // completion, read data valid now
            if (r_we)
                store[r_addr >> 2] = r_wdata;
            else
                o_rdata <= store.exists(r_addr >> 2) ? store[r_addr >> 2] : fill_word(r_addr >> 2);
        end
    end

endmodule

`default_nettype wire

// ==== sim/tb_maint.sv ====
/*
 * testbench for maint_top with memory model and credit-based stream source
 * user operation table, busy, credit and checksum checks
 */

`timescale 1ns/1ps
`default_nettype none

module tb_maint;

    localparam int MAX_BUSY = 4;
    localparam int N_OPS    = maint_pkg::ZERO_WORDS + 6;
    localparam int FAR_WORD = 40;  // written before hand-off
    // about twice the worst-case cycles per op over all init and user ops plus margin
    localparam int CYCLE_LIMIT =
        (maint_pkg::ZERO_WORDS + 2 * maint_pkg::IMAGE_WORDS + N_OPS) * (MAX_BUSY + 4) * 2 + 500;

    typedef struct packed {
        logic             is_wr;
        maint_pkg::addr_t addr;
        maint_pkg::word_t wdata;
        maint_pkg::word_t exp;
    } usr_op_t;

    logic             clk;
    logic             rst_n;
    logic             rst_seen;
    logic             ld_valid;
    maint_pkg::word_t ld_data;
    logic             ld_credit;
    logic             usr_rd;
    logic             usr_wr;
    maint_pkg::addr_t usr_addr;
    maint_pkg::word_t usr_wdata;
    maint_pkg::word_t usr_rdata;
    logic             usr_busy;
    logic             mem_req;
    logic             mem_we;
    maint_pkg::addr_t mem_addr;
    maint_pkg::word_t mem_wdata;
    maint_pkg::word_t mem_rdata;
    logic             mem_busy;
    logic [2:0]       busy_len;
    logic             init_done;
    logic             verify_ok;
    maint_pkg::word_t load_checksum;

    logic [15:0]      lfsr_state;
    maint_pkg::word_t image [maint_pkg::IMAGE_WORDS];
    usr_op_t          ops [N_OPS];
    int               credits;
    int               words_sent;
    int               credits_back;
    int               cycle_count;
    int               gap_bit;
    int               len_bits;

    maint_top dut (
        .clk(clk), .i_rst_n(rst_n),
        .i_ld_valid(ld_valid), .i_ld_data(ld_data), .o_ld_credit(ld_credit),
        .i_usr_rd(usr_rd), .i_usr_wr(usr_wr), .i_usr_addr(usr_addr),
        .i_usr_wdata(usr_wdata), .o_usr_rdata(usr_rdata), .o_usr_busy(usr_busy),
        .o_mem_req(mem_req), .o_mem_we(mem_we), .o_mem_addr(mem_addr),
        .o_mem_wdata(mem_wdata), .i_mem_rdata(mem_rdata), .i_mem_busy(mem_busy),
        .o_init_done(init_done), .o_verify_ok(verify_ok), .o_load_checksum(load_checksum)
    );

    mem_model u_mem (
        .clk(clk), .i_rst_n(rst_n), .i_req(mem_req), .i_we(mem_we), .i_addr(mem_addr),
        .i_wdata(mem_wdata), .i_busy_len(busy_len), .o_rdata(mem_rdata), .o_busy(mem_busy)
    );

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic draw_bits(input int n, output int v);
        v = 0;
        for (int i = 0; i < n; i++) begin
            v = (v << 1) | int'(lfsr_state[15]);
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    function automatic maint_pkg::word_t untouched_word(input int word_idx);
        return (maint_pkg::word_t'(word_idx) ^ 32'hDEAD_BEEF) | 32'h1;
    endfunction

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic report_mismatch(input string name, input maint_pkg::word_t got,
                                   input maint_pkg::word_t exp);
        stop_run($sformatf("MISMATCH at %0d ns: %s got %h expected %h", $time, name, got, exp));
    endtask

    task automatic set_op(input int idx, input logic is_wr, input maint_pkg::addr_t addr,
                          input maint_pkg::word_t wdata, input maint_pkg::word_t exp);
        ops[idx].is_wr = is_wr;
        ops[idx].addr  = addr;
        ops[idx].wdata = wdata;
        ops[idx].exp   = exp;
    endtask

    task automatic build_ops();
        for (int i = 0; i < maint_pkg::ZERO_WORDS; i++) begin
            if (i < maint_pkg::IMAGE_WORDS)
                set_op(i, 1'b0, maint_pkg::addr_t'(i * 4), '0, image[i]);
            else
                set_op(i, 1'b0, maint_pkg::addr_t'(i * 4), '0, '0);  // zero fill region
        end
        set_op(N_OPS - 6, 1'b0, FAR_WORD * 4, '0, untouched_word(FAR_WORD));
        set_op(N_OPS - 5, 1'b1, 20 * 4, 32'hCAFE_F00D, '0);
        set_op(N_OPS - 4, 1'b0, 20 * 4, '0, 32'hCAFE_F00D);
        set_op(N_OPS - 3, 1'b0, 32'h1000_0000 | (20 * 4), '0, 32'hCAFE_F00D);  // above window
        set_op(N_OPS - 2, 1'b1, 32'h4000_0000 | (21 * 4), 32'h1357_9BDF, '0);
        set_op(N_OPS - 1, 1'b0, 21 * 4, '0, 32'h1357_9BDF);
    endtask

    // one user bus transfer between falling edges
    task automatic run_user_op(input usr_op_t op, output maint_pkg::word_t rdata);
        while (usr_busy)
            @(negedge clk);
        usr_rd    = !op.is_wr;
        usr_wr    = op.is_wr;
        usr_addr  = op.addr;
        usr_wdata = op.wdata;
        @(negedge clk);
        usr_rd = 1'b0;
        usr_wr = 1'b0;
        while (!usr_busy)
            @(negedge clk);
        while (usr_busy)
            @(negedge clk);
        rdata = usr_rdata;
    endtask

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk)
        rst_seen <= rst_n;

    // LFSR draws then the stream source
    always @(negedge clk) begin
        draw_bits(1, gap_bit);
        draw_bits(2, len_bits);
        busy_len = 3'(len_bits + 1);
        ld_valid = 1'b0;
        if (rst_seen) begin
            if (ld_credit) begin
                credits++;
                credits_back++;
            end
            assert (credits <= maint_pkg::LOAD_CREDITS)
                else stop_run("stream source got back more credits than it started with");
            if (credits > 0 && words_sent < maint_pkg::IMAGE_WORDS && gap_bit == 1) begin
                ld_valid = 1'b1;
                ld_data  = image[words_sent];
                words_sent++;
                credits--;
            end
        end
    end

    always @(negedge clk) begin
        if (rst_seen && !init_done)
            assert (usr_busy) else stop_run("user busy went low before init was done");
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < CYCLE_LIMIT) begin
            @(posedge clk);
            cycle_count++;
        end
        stop_run($sformatf("timeout after %0d cycles", CYCLE_LIMIT));
    end

    initial begin
        maint_pkg::word_t got;
        maint_pkg::word_t sum;
        rst_n        = 1'b0;
        ld_valid     = 1'b0;
        ld_data      = '0;
        usr_rd       = 1'b0;
        usr_wr       = 1'b0;
        usr_addr     = '0;
        usr_wdata    = '0;
        busy_len     = 3'd1;
        lfsr_state   = 16'd13;
        credits      = maint_pkg::LOAD_CREDITS;
        words_sent   = 0;
        credits_back = 0;
        image = '{32'h1111_0001, 32'h2222_0002, 32'h8000_0000, 32'hFFFF_FFFF,
                  32'h0BAD_F00D, 32'h1234_5678, 32'hC0DE_0007, 32'hFFFF_FFFE};
        build_ops();
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        // user write during init is dropped by the mux
        usr_wr    = 1'b1;
        usr_addr  = FAR_WORD * 4;
        usr_wdata = 32'hBAD0_BAD0;
        repeat (3) @(negedge clk);
        usr_wr = 1'b0;
        while (!init_done)
            @(negedge clk);

        sum = '0;
        foreach (image[i])
            sum += image[i];  // wraps mod 2^32
        assert (load_checksum == sum) else report_mismatch("o_load_checksum", load_checksum, sum);
        assert (verify_ok) else stop_run("o_verify_ok is low after init done");
        assert (words_sent == maint_pkg::IMAGE_WORDS && credits_back == maint_pkg::IMAGE_WORDS)
            else stop_run("stream source sent or got back the wrong number of words");
        assert (credits == maint_pkg::LOAD_CREDITS)
            else stop_run("stream source did not get all its credits back");

        foreach (ops[i]) begin
            run_user_op(ops[i], got);
            if (!ops[i].is_wr)
                assert (got == ops[i].exp)
                    else report_mismatch($sformatf("o_usr_rdata op %0d", i), got, ops[i].exp);
        end

        $display("Test passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== all.f ====
common/maint_pkg.sv
common/mem_req_if.sv
hw/init/init_sequencer.sv
hw/init/checksum_unit.sv
hw/mem_port_mux.sv
hw/maint_top.sv
sim/mem_model.sv
sim/tb_maint.sv

// ==== Bender.yml ====
package:
  name: maint

sources:
  - files:
      - common/maint_pkg.sv
      - common/mem_req_if.sv
      - hw/init/init_sequencer.sv
      - hw/init/checksum_unit.sv
      - hw/mem_port_mux.sv
      - hw/maint_top.sv
  - target: simulation
    files:
      - sim/mem_model.sv
      - sim/tb_maint.sv
